// File: include/paging_core_config.svh
`ifndef PAGING_CORE_CONFIG_SVH
`define PAGING_CORE_CONFIG_SVH

// physical memory and paging geometry
`define CFG_MEM_WORDS 1024  // words of physical memory
`define CFG_PAGE_SIZE 72  // words per page
`define CFG_NUM_PAGES 14  // whole pages that fit in memory

// program layout
`define CFG_PROGRAM_BASE 46  // reset pc, data below it is off limits

`define CFG_NUM_REGS 8  // general purpose registers

`endif

// File: design/isa_pkg.sv
`default_nettype none

package isa_pkg;

  typedef logic [15:0] word_t;  // data word
  typedef logic [2:0] reg_idx_t;  // register number

  typedef enum logic [7:0] {
    op_jmp       = 8'd1,
    op_ram2reg   = 8'd2,
    op_reg2ram   = 8'd3,
    op_num2reg   = 8'd4,
    op_reg_plus  = 8'd5,
    op_reg_minus = 8'd6,
    op_exit      = 8'd17
  } opcode_e;  // anything else runs as a no-op

  typedef struct packed {
    opcode_e    opcode;  // high byte of word 1
    logic [7:0] reg_byte;  // low byte of word 1
    word_t      operand;  // word 2
  } instr_t;

  typedef enum logic [2:0] {
    st_fetch_hi,
    st_fetch_lo,
    st_decode,
    st_xlate,
    st_mem_access,
    st_halted,
    st_fault
  } seq_state_e;

endpackage

`default_nettype wire

// File: design/mem_pkg.sv
`default_nettype none

package mem_pkg;

  typedef logic [9:0] laddr_t;  // logical address
  typedef logic [9:0] paddr_t;  // physical address
  typedef logic [3:0] page_idx_t;  // logical or physical page

  typedef struct packed {
    logic           write;  // 1 for a store
    paddr_t         addr;
    isa_pkg::word_t wdata;  // ignored on a read
  } mem_cmd_t;

  typedef struct packed {
    laddr_t laddr;
  } xlate_req_t;

endpackage

`default_nettype wire

// File: design/reg_file_alu.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file_alu import isa_pkg::*; (
  input  logic     clka,
  input  logic     rst_n,
  input  opcode_e  rf_op,
  input  reg_idx_t rf_idx,
  input  word_t    rf_wdata,
  input  logic     rf_we,
  output word_t    rf_rdata
);

  word_t regs [2**$bits(reg_idx_t)];

  assign rf_rdata = regs[rf_idx];  // asynchronous read

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**$bits(reg_idx_t); i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we) begin
      case (rf_op)
        op_num2reg, op_ram2reg: regs[rf_idx] <= rf_wdata;
        op_reg_plus: regs[rf_idx] <= regs[rf_idx] + rf_wdata;
        op_reg_minus: regs[rf_idx] <= regs[rf_idx] - rf_wdata;  // wraps modulo 2^16
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module mem_port import isa_pkg::*, mem_pkg::*; (
  input  logic     clka,
  input  logic     rst_n,
  input  logic     port_start,
  input  mem_cmd_t port_cmd,
  output logic     port_done,
  output word_t    port_rdata,
  output logic     mem_req,
  output mem_cmd_t mem_cmd,
  input  logic     mem_ack,
  input  word_t    mem_rdata
);

  typedef enum logic [1:0] {
    idle,
    wait_ack,
    wait_release
  } port_state_e;

  port_state_e state;

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      state     <= idle;
      mem_req   <= 1'b0;
      port_done <= 1'b0;
    end else begin
      port_done <= 1'b0;
      case (state)
        idle: begin
          if (port_start) begin
            mem_req <= 1'b1;
            state   <= wait_ack;
          end
        end
        wait_ack: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            state   <= wait_release;
          end
        end
        wait_release: begin
          if (!mem_ack) begin
            port_done <= 1'b1;  // memory is free for the next request
            state     <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (state == idle && port_start) begin
      mem_cmd <= port_cmd;  // held for the whole transfer
    end
    if (state == wait_ack && mem_ack) begin
      port_rdata <= mem_rdata;
    end
  end

  req_held_until_ack: assert property (@(posedge clka) disable iff (!rst_n)
    mem_req && !mem_ack |=> mem_req);

endmodule

`default_nettype wire

// File: design/free_page_scan.sv
`timescale 1ns/10ps
`default_nettype none

`include "paging_core_config.svh"

module free_page_scan import mem_pkg::*; (
  input  logic                      clka,
  input  logic                      rst_n,
  input  logic                      scan_start,
  input  logic [`CFG_NUM_PAGES-1:0] page_used,
  output logic                      scan_done,
  output logic                      scan_none,
  output page_idx_t                 scan_page
);

  logic      busy;
  page_idx_t cnt;
  page_idx_t start;  // rotates past each page handed out
  page_idx_t tried;

  function automatic page_idx_t step(page_idx_t p);
    return (p == page_idx_t'(`CFG_NUM_PAGES - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      cnt       <= '0;
      start     <= page_idx_t'(1);
      tried     <= '0;
      scan_done <= 1'b0;
      scan_none <= 1'b0;
      scan_page <= '0;
    end else begin
      scan_done <= 1'b0;
      scan_none <= 1'b0;
      if (scan_start) begin
        busy  <= 1'b1;
        cnt   <= start;
        tried <= '0;
      end else if (busy) begin
        if (!page_used[cnt]) begin
          scan_done <= 1'b1;
          scan_page <= cnt;
          start     <= step(cnt);
          busy      <= 1'b0;
        end else if (tried == page_idx_t'(`CFG_NUM_PAGES - 1)) begin
          scan_done <= 1'b1;  // full circle, memory is full
          scan_none <= 1'b1;
          busy      <= 1'b0;
        end else begin
          cnt   <= step(cnt);
          tried <= tried + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/page_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "paging_core_config.svh"

module page_table import mem_pkg::*; (
  input  logic                      clka,
  input  logic                      rst_n,
  input  logic                      xlate_start,
  input  xlate_req_t                xlate_req,
  output logic                      xlate_done,
  output logic                      xlate_fault,
  output paddr_t                    xlate_paddr,
  output logic                      scan_start,
  output logic [`CFG_NUM_PAGES-1:0] page_used,
  input  logic                      scan_done,
  input  logic                      scan_none,
  input  page_idx_t                 scan_page
);

  typedef enum logic [1:0] {
    pt_idle,
    pt_walk,
    pt_alloc
  } pt_state_e;

  pt_state_e                 state;
  page_idx_t                 next_pg [`CFG_NUM_PAGES];  // chain link, tail points to itself
  page_idx_t                 lpage [`CFG_NUM_PAGES];  // logical page held by each physical page
  logic [`CFG_NUM_PAGES-1:0] used;
  page_idx_t                 cache_lp;
  page_idx_t                 cache_pp;
  page_idx_t                 req_lp;
  logic [6:0]                req_off;
  page_idx_t                 cur;
  page_idx_t                 tail;
  page_idx_t                 new_lp;
  logic [6:0]                new_off;

  assign new_lp    = page_idx_t'(xlate_req.laddr / `CFG_PAGE_SIZE);
  assign new_off   = 7'(xlate_req.laddr % `CFG_PAGE_SIZE);
  assign page_used = used;

  function automatic paddr_t to_paddr(page_idx_t pg, logic [6:0] off);
    return paddr_t'(pg) * paddr_t'(`CFG_PAGE_SIZE) + paddr_t'(off);
  endfunction

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      state       <= pt_idle;
      xlate_done  <= 1'b0;
      xlate_fault <= 1'b0;
      xlate_paddr <= '0;
      scan_start  <= 1'b0;
      cache_lp    <= '0;  // logical 0 sits in physical 0
      cache_pp    <= '0;
      req_lp      <= '0;
      req_off     <= '0;
      cur         <= '0;
      tail        <= '0;
      for (int i = 0; i < `CFG_NUM_PAGES; i++) begin
        next_pg[i] <= page_idx_t'(i);
        lpage[i]   <= '0;
      end
      used    <= '0;
      used[0] <= 1'b1;
    end else begin
      xlate_done  <= 1'b0;
      xlate_fault <= 1'b0;
      scan_start  <= 1'b0;
      case (state)
        pt_idle: begin
          if (xlate_start) begin
            req_lp  <= new_lp;
            req_off <= new_off;
            if (new_lp == cache_lp) begin
              xlate_done  <= 1'b1;
              xlate_paddr <= to_paddr(cache_pp, new_off);
            end else begin
              cur   <= '0;  // chain always starts at page 0
              state <= pt_walk;
            end
          end
        end
        pt_walk: begin
          if (used[cur] && lpage[cur] == req_lp) begin
            xlate_done  <= 1'b1;
            xlate_paddr <= to_paddr(cur, req_off);
            cache_lp    <= req_lp;
            cache_pp    <= cur;
            state       <= pt_idle;
          end else if (next_pg[cur] == cur) begin
            tail       <= cur;  // end of chain, go find a free page
            scan_start <= 1'b1;
            state      <= pt_alloc;
          end else begin
            cur <= next_pg[cur];
          end
        end
        pt_alloc: begin
          if (scan_done) begin
            xlate_done <= 1'b1;
            state      <= pt_idle;
            if (scan_none) begin
              xlate_fault <= 1'b1;
            end else begin
              next_pg[tail]      <= scan_page;
              next_pg[scan_page] <= scan_page;  // new tail
              lpage[scan_page]   <= req_lp;
              used[scan_page]    <= 1'b1;
              xlate_paddr        <= to_paddr(scan_page, req_off);
              cache_lp           <= req_lp;
              cache_pp           <= scan_page;
            end
          end
        end
        default: state <= pt_idle;
      endcase
    end
  end

  // scanner must only hand back whole pages inside memory
  paddr_in_range: assert property (@(posedge clka) disable iff (!rst_n)
    xlate_done && !xlate_fault |-> xlate_paddr < paddr_t'(`CFG_NUM_PAGES * `CFG_PAGE_SIZE));

endmodule

`default_nettype wire

// File: design/exec_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "paging_core_config.svh"

module exec_sequencer import isa_pkg::*, mem_pkg::*; (
  input  logic       clka,
  input  logic       rst_n,
  output logic       xlate_start,
  output xlate_req_t xlate_req,
  input  logic       xlate_done,
  input  logic       xlate_fault,
  input  paddr_t     xlate_paddr,
  output logic       port_start,
  output mem_cmd_t   port_cmd,
  input  logic       port_done,
  input  word_t      port_rdata,
  output opcode_e    rf_op,
  output reg_idx_t   rf_idx,
  output word_t      rf_wdata,
  output logic       rf_we,
  input  word_t      rf_rdata,
  output logic       halted,
  output logic       fault
);

  typedef enum logic [1:0] {
    acc_hi,  // first instruction word
    acc_lo,  // operand word
    acc_data  // ram2reg or reg2ram access
  } acc_e;

  seq_state_e state;
  acc_e       acc;
  laddr_t     pc;
  instr_t     instr;
  logic       data_ok;
  logic       is_store;

  // operand must point into program space
  assign data_ok = (instr.operand >= word_t'(`CFG_PROGRAM_BASE)) &&
                   (instr.operand < word_t'(`CFG_MEM_WORDS));
  assign is_store = (acc == acc_data) && (instr.opcode == op_reg2ram);

  assign rf_op    = instr.opcode;
  assign rf_idx   = reg_idx_t'(instr.reg_byte);  // upper bits of the byte are ignored
  assign rf_wdata = (instr.opcode == op_ram2reg) ? port_rdata : instr.operand;

  assign halted = (state == st_halted);
  assign fault  = (state == st_fault);

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      state       <= st_fetch_hi;
      acc         <= acc_hi;
      pc          <= laddr_t'(`CFG_PROGRAM_BASE);
      instr       <= '0;
      xlate_start <= 1'b0;
      xlate_req   <= '0;
      port_start  <= 1'b0;
      port_cmd    <= '0;
      rf_we       <= 1'b0;
    end else begin
      xlate_start <= 1'b0;
      port_start  <= 1'b0;
      rf_we       <= 1'b0;
      case (state)
        st_fetch_hi: begin
          xlate_start     <= 1'b1;
          xlate_req.laddr <= pc;
          acc             <= acc_hi;
          state           <= st_xlate;
        end
        st_fetch_lo: begin
          xlate_start     <= 1'b1;
          xlate_req.laddr <= pc;
          acc             <= acc_lo;
          state           <= st_xlate;
        end
        st_xlate: begin
          if (xlate_done) begin
            if (xlate_fault) begin
              state <= st_fault;  // no free page left
            end else begin
              port_start     <= 1'b1;
              port_cmd.write <= is_store;
              port_cmd.addr  <= xlate_paddr;
              port_cmd.wdata <= rf_rdata;  // register is stable since decode
              state          <= st_mem_access;
            end
          end
        end
        st_mem_access: begin
          if (port_done) begin
            case (acc)
              acc_hi: begin
                instr.opcode   <= opcode_e'(port_rdata[15:8]);
                instr.reg_byte <= port_rdata[7:0];
                pc             <= pc + 1'b1;
                state          <= st_fetch_lo;
              end
              acc_lo: begin
                instr.operand <= port_rdata;
                pc            <= pc + 1'b1;
                state         <= st_decode;
              end
              default: begin
                rf_we <= (instr.opcode == op_ram2reg);  // load takes port_rdata
                state <= st_fetch_hi;
              end
            endcase
          end
        end
        st_decode: begin
          state <= st_fetch_hi;
          case (instr.opcode)
            op_jmp: begin
              if (data_ok) pc <= laddr_t'(instr.operand);
            end
            op_ram2reg, op_reg2ram: begin
              if (data_ok) begin
                xlate_start     <= 1'b1;
                xlate_req.laddr <= laddr_t'(instr.operand);
                acc             <= acc_data;
                state           <= st_xlate;
              end
            end
            op_num2reg, op_reg_plus, op_reg_minus: rf_we <= 1'b1;
            op_exit: state <= st_halted;
            default: ;  // loop opcodes and unknown values
          endcase
        end
        default: ;  // halted and fault are terminal
      endcase
    end
  end

  // once stopped the core stays stopped and starts no transfer
  stop_is_final: assert property (@(posedge clka) disable iff (!rst_n)
    (halted || fault) |=> (halted || fault) && !port_start);

endmodule

`default_nettype wire

// File: design/paging_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "paging_core_config.svh"

module paging_core import isa_pkg::*, mem_pkg::*; (
  input  logic     clka,
  input  logic     rst_n,
  output logic     mem_req,
  output mem_cmd_t mem_cmd,
  input  logic     mem_ack,
  input  word_t    mem_rdata,
  output logic     halted,
  output logic     fault
);

  logic       xlate_start;
  xlate_req_t xlate_req;
  logic       xlate_done;
  logic       xlate_fault;
  paddr_t     xlate_paddr;

  logic     port_start;
  mem_cmd_t port_cmd;
  logic     port_done;
  word_t    port_rdata;

  logic                      scan_start;
  logic [`CFG_NUM_PAGES-1:0] page_used;
  logic                      scan_done;
  logic                      scan_none;
  page_idx_t                 scan_page;

  opcode_e  rf_op;
  reg_idx_t rf_idx;
  word_t    rf_wdata;
  logic     rf_we;
  word_t    rf_rdata;

  exec_sequencer exec_sequencer_inst (
    .clka       (clka),
    .rst_n      (rst_n),
    .xlate_start(xlate_start),
    .xlate_req  (xlate_req),
    .xlate_done (xlate_done),
    .xlate_fault(xlate_fault),
    .xlate_paddr(xlate_paddr),
    .port_start (port_start),
    .port_cmd   (port_cmd),
    .port_done  (port_done),
    .port_rdata (port_rdata),
    .rf_op      (rf_op),
    .rf_idx     (rf_idx),
    .rf_wdata   (rf_wdata),
    .rf_we      (rf_we),
    .rf_rdata   (rf_rdata),
    .halted     (halted),
    .fault      (fault)
  );

  page_table page_table_inst (
    .clka       (clka),
    .rst_n      (rst_n),
    .xlate_start(xlate_start),
    .xlate_req  (xlate_req),
    .xlate_done (xlate_done),
    .xlate_fault(xlate_fault),
    .xlate_paddr(xlate_paddr),
    .scan_start (scan_start),
    .page_used  (page_used),
    .scan_done  (scan_done),
    .scan_none  (scan_none),
    .scan_page  (scan_page)
  );

  free_page_scan free_page_scan_inst (
    .clka      (clka),
    .rst_n     (rst_n),
    .scan_start(scan_start),
    .page_used (page_used),
    .scan_done (scan_done),
    .scan_none (scan_none),
    .scan_page (scan_page)
  );

  reg_file_alu reg_file_alu_inst (
    .clka    (clka),
    .rst_n   (rst_n),
    .rf_op   (rf_op),
    .rf_idx  (rf_idx),
    .rf_wdata(rf_wdata),
    .rf_we   (rf_we),
    .rf_rdata(rf_rdata)
  );

  mem_port mem_port_inst (
    .clka      (clka),
    .rst_n     (rst_n),
    .port_start(port_start),
    .port_cmd  (port_cmd),
    .port_done (port_done),
    .port_rdata(port_rdata),
    .mem_req   (mem_req),
    .mem_cmd   (mem_cmd),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// File: dv/tb_paging_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "paging_core_config.svh"

module tb_paging_core import isa_pkg::*, mem_pkg::*;;

  localparam int mem_words     = `CFG_MEM_WORDS;
  localparam int page_size     = `CFG_PAGE_SIZE;
  localparam int num_pages     = `CFG_NUM_PAGES;
  localparam int prog_base     = `CFG_PROGRAM_BASE;
  localparam int num_regs      = `CFG_NUM_REGS;
  localparam int nlpages       = (mem_words + page_size - 1) / page_size;  // logical pages
  localparam int max_steps     = 200;
  localparam int settle_cycles = 20;  // quiet window after the core stops

  typedef enum logic [1:0] {
    resp_idle,
    resp_wait,
    resp_ack
  } resp_state_e;

  logic     clka = 1'b0;
  logic     rst_n = 1'b0;
  logic     mem_req;
  mem_cmd_t mem_cmd;
  logic     mem_ack = 1'b0;
  word_t    mem_rdata = '0;
  logic     halted;
  logic     fault;

  logic [31:0] rng_state = 32'hc19965bb;
  word_t       prog_img [mem_words];  // program and data as written by the test
  word_t       model_mem [mem_words];
  word_t       dut_mem [mem_words];  // what the responder serves in logical space
  int          lp_to_pp [nlpages];
  int          pp_to_lp [num_pages];
  int          next_phys;
  int          exp_addr [$];
  word_t       exp_data [$];
  int          page_order [$];
  int          exp_xfers;
  int          xfer_count;
  bit          exp_halt;
  bit          exp_fault;
  int          n_instr;
  int          wp;
  int          error_count;
  int          tests_passed;
  int          tests_failed;
  longint      cycle_count;
  longint      cycle_limit;
  resp_state_e resp_state;
  mem_cmd_t    held_cmd;
  int          delay;

  paging_core paging_core_inst (
    .clka     (clka),
    .rst_n    (rst_n),
    .mem_req  (mem_req),
    .mem_cmd  (mem_cmd),
    .mem_ack  (mem_ack),
    .mem_rdata(mem_rdata),
    .halted   (halted),
    .fault    (fault)
  );

  always #5 clka = ~clka;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int rand_below(int n);
    return int'(next_rand() % 32'(n));
  endfunction

  task automatic note_mismatch(string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic note_failure(string msg);
    $display("ERROR at %0t: %s", $time, msg);
    error_count++;
  endtask

  // first touch takes the next free physical page above 0
  function automatic bit claim_page(int laddr);
    int lp;
    lp = laddr / page_size;
    if (lp_to_pp[lp] >= 0) return 1'b1;
    if (next_phys >= num_pages) return 1'b0;
    lp_to_pp[lp]        = next_phys;
    pp_to_lp[next_phys] = lp;
    next_phys++;
    return 1'b1;
  endfunction

  function automatic int phys_of(int laddr);
    return lp_to_pp[laddr / page_size] * page_size + laddr % page_size;
  endfunction

  function automatic word_t addr_in_page(int lp);
    int span;
    span = (lp == nlpages - 1) ? mem_words - lp * page_size : page_size;  // last page is short
    return word_t'(lp * page_size + rand_below(span));
  endfunction

  task automatic fill_image();
    for (int a = 0; a < mem_words; a++) begin
      prog_img[a] = word_t'(next_rand()) ^ word_t'(a);
    end
    wp = prog_base;
  endtask

  task automatic put_instr(logic [7:0] op, int r, word_t operand);
    logic [31:0] rv;
    rv = next_rand();
    prog_img[wp]     = {op, rv[7:3], 3'(r)};  // junk in the upper register bits
    prog_img[wp + 1] = operand;
    wp += 2;
  endtask

  task automatic shuffle_pages(int first, int last);
    int j;
    int t;
    page_order.delete();
    for (int p = first; p <= last; p++) begin
      page_order.push_back(p);
    end
    for (int i = page_order.size() - 1; i > 0; i--) begin
      j             = rand_below(i + 1);
      t             = page_order[i];
      page_order[i] = page_order[j];
      page_order[j] = t;
    end
  endtask

  // runs the program in logical space and predicts writes and transfers
  task automatic run_model();
    word_t regs [num_regs];
    word_t w1;
    int    pc;
    int    opnd;
    int    r;
    bit    in_range;
    for (int i = 0; i < nlpages; i++) begin
      lp_to_pp[i] = -1;
    end
    for (int i = 0; i < num_pages; i++) begin
      pp_to_lp[i] = -1;
    end
    for (int i = 0; i < num_regs; i++) begin
      regs[i] = '0;
    end
    for (int a = 0; a < mem_words; a++) begin
      model_mem[a] = prog_img[a];
    end
    lp_to_pp[0] = 0;
    pp_to_lp[0] = 0;
    next_phys   = 1;
    exp_addr.delete();
    exp_data.delete();
    exp_halt  = 1'b0;
    exp_fault = 1'b0;
    exp_xfers = 0;
    n_instr   = 0;
    pc        = prog_base;
    while (!exp_halt && n_instr < max_steps) begin
      n_instr++;
      if (!claim_page(pc)) begin
        exp_fault = 1'b1;
        break;
      end
      exp_xfers++;
      w1 = model_mem[pc];
      pc = (pc + 1) % mem_words;
      if (!claim_page(pc)) begin
        exp_fault = 1'b1;
        break;
      end
      exp_xfers++;
      opnd     = int'(model_mem[pc]);
      pc       = (pc + 1) % mem_words;
      r        = int'(w1[2:0]);
      in_range = (opnd >= prog_base) && (opnd < mem_words);
      case (w1[15:8])
        op_jmp: begin
          if (in_range) pc = opnd;
        end
        op_ram2reg, op_reg2ram: begin
          if (in_range) begin
            if (!claim_page(opnd)) begin
              exp_fault = 1'b1;
              break;
            end
            exp_xfers++;
            if (w1[15:8] == op_ram2reg) begin
              regs[r] = model_mem[opnd];
            end else begin
              model_mem[opnd] = regs[r];
              exp_addr.push_back(phys_of(opnd));
              exp_data.push_back(regs[r]);
            end
          end
        end
        op_num2reg: regs[r] = word_t'(opnd);
        op_reg_plus: regs[r] = regs[r] + word_t'(opnd);
        op_reg_minus: regs[r] = regs[r] - word_t'(opnd);
        op_exit: exp_halt = 1'b1;
        default: ;
      endcase
    end
  endtask

  task automatic check_write(int paddr, word_t data);
    int    ea;
    word_t ed;
    assert (exp_addr.size() > 0) else
      note_failure($sformatf("write to %0d when no write was expected", paddr));
    if (exp_addr.size() > 0) begin
      ea = exp_addr.pop_front();
      ed = exp_data.pop_front();
      assert (paddr == ea && data == ed) else
        note_mismatch($sformatf("write %0d <= %h, expected %0d <= %h", paddr, data, ea, ed));
    end
  endtask

  // four-phase slave with a random ack delay that maps through the model's page table
  always @(posedge clka) begin : responder
    int    paddr;
    int    pp;
    int    la;
    word_t rdata;
    if (!rst_n) begin
      resp_state = resp_idle;
      #1 mem_ack = 1'b0;
    end else begin
      if (resp_state == resp_idle && mem_req) begin
        assert (!halted && !fault) else note_failure("mem_req raised after the core stopped");
        held_cmd   = mem_cmd;
        delay      = rand_below(4);
        resp_state = resp_wait;
      end
      if (resp_state == resp_wait) begin
        assert (mem_req && mem_cmd == held_cmd) else
          note_failure("mem_req or mem_cmd changed before mem_ack");
        if (delay > 0) begin
          delay--;
        end else begin
          rdata = '0;
          paddr = int'(held_cmd.addr);
          pp    = paddr / page_size;
          la    = -1;
          if (pp < num_pages && pp_to_lp[pp] >= 0) begin
            la = pp_to_lp[pp] * page_size + paddr % page_size;
          end
          assert (la >= 0 && la < mem_words) else
            note_failure($sformatf("access to unmapped physical address %0d", paddr));
          if (la >= 0 && la < mem_words) begin
            if (held_cmd.write) begin
              check_write(paddr, held_cmd.wdata);
              dut_mem[la] = held_cmd.wdata;
            end else begin
              rdata = dut_mem[la];
            end
          end
          xfer_count++;
          resp_state = resp_ack;
          #1;
          mem_rdata = rdata;
          mem_ack   = 1'b1;
        end
      end else if (resp_state == resp_ack) begin
        if (!mem_req) begin
          resp_state = resp_idle;
          #1 mem_ack = 1'b0;
        end else begin
          assert (mem_cmd == held_cmd) else note_failure("mem_cmd changed while mem_ack was high");
        end
      end
    end
  end

  always @(posedge clka) begin : watchdog
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the core did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic apply_reset();
    @(posedge clka);
    #1 rst_n = 1'b0;
    repeat (3) @(posedge clka);
    #1 rst_n = 1'b1;
  endtask

  task automatic build_arith_store();
    int r;
    fill_image();
    for (int i = 0; i < 14; i++) begin
      r = rand_below(num_regs);
      case (rand_below(4))
        0: put_instr(op_num2reg, r, word_t'(next_rand()));
        1: put_instr(op_reg_plus, r, word_t'(next_rand()));
        2: put_instr(op_reg_minus, r, word_t'(next_rand()));
        default: put_instr(op_reg2ram, r, addr_in_page(2 + rand_below(3)));
      endcase
    end
    for (int i = 0; i < num_regs; i++) begin
      put_instr(op_reg2ram, i, addr_in_page(2 + rand_below(3)));
    end
    put_instr(op_exit, 0, '0);
  endtask

  task automatic build_load_store();
    int r;
    fill_image();  // random fill is the preloaded data
    for (int i = 0; i < 6; i++) begin
      r = rand_below(num_regs);
      put_instr(op_ram2reg, r, addr_in_page(2 + rand_below(3)));
      if (rand_below(2) == 1) put_instr(op_reg_plus, r, word_t'(next_rand()));
      put_instr(op_reg2ram, r, addr_in_page(5 + rand_below(3)));
    end
    put_instr(op_exit, 0, '0);
  endtask

  task automatic build_guard_jump();
    int skip;
    fill_image();
    for (int i = 0; i < num_regs; i++) begin
      put_instr(op_num2reg, i, word_t'(next_rand()));
    end
    put_instr(op_ram2reg, 0, word_t'(rand_below(prog_base)));  // below program base
    put_instr(op_reg2ram, 1, word_t'(rand_below(prog_base)));
    put_instr(op_jmp, 0, word_t'(rand_below(prog_base)));
    put_instr(op_jmp, 0, word_t'(mem_words + rand_below(1024)));  // past the memory
    put_instr(op_ram2reg, 2, 16'hffff);
    put_instr(8'd9, 3, word_t'(next_rand()));  // loop opcode runs as a no-op
    skip = 1 + rand_below(3);
    put_instr(op_jmp, 0, word_t'(wp + 2 + 2 * skip));
    for (int i = 0; i < skip; i++) begin
      put_instr(op_reg2ram, rand_below(num_regs), addr_in_page(3));  // jumped over
    end
    for (int i = 0; i < num_regs; i++) begin
      put_instr(op_reg2ram, i, addr_in_page(2));
    end
    put_instr(op_exit, 0, '0);
  endtask

  // one store per data page with the pages in random order
  task automatic build_page_walk(int last_page);
    int r;
    fill_image();
    shuffle_pages(2, last_page);
    foreach (page_order[i]) begin
      r = rand_below(num_regs);
      put_instr(op_num2reg, r, word_t'(next_rand()));
      put_instr(op_reg2ram, r, addr_in_page(page_order[i]));
    end
    put_instr(op_exit, 0, '0);
  endtask

  task automatic build_exit();
    int r;
    fill_image();
    for (int i = 0; i < 6; i++) begin
      r = rand_below(num_regs);
      put_instr(op_num2reg, r, word_t'(next_rand()));
      put_instr(op_reg2ram, r, addr_in_page(2 + rand_below(4)));
    end
    put_instr(op_exit, rand_below(num_regs), word_t'(next_rand()));
    for (int i = 0; i < 4; i++) begin
      put_instr(op_reg2ram, rand_below(num_regs), addr_in_page(6));  // never reached
    end
  endtask

  task automatic run_test(int id, string name);
    int errors_before;
    int n_writes;
    errors_before = error_count;
    run_model();
    n_writes    = exp_addr.size();
    cycle_limit += longint'(400 * n_instr);
    for (int a = 0; a < mem_words; a++) begin
      dut_mem[a] = prog_img[a];
    end
    xfer_count = 0;
    apply_reset();
    while (!halted && !fault) @(negedge clka);
    repeat (settle_cycles) @(negedge clka);
    assert (halted == exp_halt && fault == exp_fault) else
      note_mismatch($sformatf("halted %b fault %b, expected halted %b fault %b",
                              halted, fault, exp_halt, exp_fault));
    assert (exp_addr.size() == 0) else
      note_failure($sformatf("%0d expected writes never reached memory", exp_addr.size()));
    assert (xfer_count == exp_xfers) else
      note_mismatch($sformatf("%0d transfers, expected %0d", xfer_count, exp_xfers));
    assert (!mem_req) else note_failure("mem_req still high after the core stopped");
    if (error_count == errors_before) begin
      tests_passed++;
      $display("test %0d %s: ok, %0d instructions, %0d writes", id, name, n_instr, n_writes);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", id, name, error_count - errors_before);
    end
  endtask

  initial begin : main
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycle_count  = 0;
    cycle_limit  = 0;
    build_arith_store();
    run_test(1, "arith_store");
    build_load_store();
    run_test(2, "load_store");
    build_guard_jump();
    run_test(3, "guard_jump");
    build_page_walk(13);  // fills every physical page
    run_test(4, "page_alloc");
    build_page_walk(nlpages - 1);  // one logical page too many
    run_test(5, "page_fault");
    build_exit();
    run_test(6, "exit");
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests_passed + tests_failed, tests_passed, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
design/isa_pkg.sv
design/mem_pkg.sv
design/reg_file_alu.sv
design/mem_port.sv
design/free_page_scan.sv
design/page_table.sv
design/exec_sequencer.sv
design/paging_core.sv
dv/tb_paging_core.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	  --top-module tb_paging_core -Mdir obj_dir -f compile.f
	@out=$$(./obj_dir/Vtb_paging_core); \
	  echo "$$out"; \
	  echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
